/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_pitch_display
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
RUN_FLAGS ?=

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_pitch_display.sv */
module tb_pitch_display
	import pitch_pkg::*;
();

	localparam int player_r = 25;
	localparam int ball_r = 5;
	localparam int frame_timeout = 1200000; // cycles, about 700k expected per frame

	logic clk = 1'b0;
	logic rst;
	logic pixel_en;
	coord_t team1_ver_pos;
	coord_t team1_hor_pos;
	coord_t team2_ver_pos;
	coord_t team2_hor_pos;
	coord_t ball_x;
	coord_t ball_y;
	logic [6:0] team1_score;
	logic [6:0] team2_score;
	logic hsync;
	logic vsync;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	int mx;
	int my;
	int snap [0:7]; // t1 ver, t1 hor, t2 ver, t2 hor, ball x, ball y, score 1, score 2
	logic [25:0] exp_mid; // {hsync, vsync, rgb} after stage 2
	logic [25:0] exp_out;
	int frames_done;
	int edges;

	always #20 clk = ~clk;

	pitch_display pitch_display_inst (
		.clk(clk),
		.rst(rst),
		.pixel_en(pixel_en),
		.team1_ver_pos(team1_ver_pos),
		.team1_hor_pos(team1_hor_pos),
		.team2_ver_pos(team2_ver_pos),
		.team2_hor_pos(team2_hor_pos),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.team1_score(team1_score),
		.team2_score(team2_score),
		.hsync(hsync),
		.vsync(vsync),
		.red(red),
		.green(green),
		.blue(blue)
	);

	function automatic logic disc(int px, int py, int cx, int cy, int r);
		return (px - cx) * (px - cx) + (py - cy) * (py - cy) < r * r;
	endfunction

	// segment order top, upper right, lower right, bottom, lower left, upper left, middle
	function automatic logic seg_on(int d, int s);
		case (s)
			0: return !(d == 1 || d == 4);
			1: return !(d == 5 || d == 6);
			2: return d != 2;
			3: return !(d == 1 || d == 4 || d == 7);
			4: return d == 0 || d == 2 || d == 6 || d == 8;
			5: return !(d == 1 || d == 2 || d == 3 || d == 7);
			default: return !(d == 0 || d == 1 || d == 7);
		endcase
	endfunction

	function automatic logic digit_hit(int px, int py, int d, int ox, int oy);
		int dx;
		int dy;
		logic [6:0] box;
		logic hit;
		dx = px - ox;
		dy = py - oy;
		box[0] = dx >= -7 && dx <= 7 && dy >= -19 && dy <= -17;
		box[1] = dx >= 8 && dx <= 10 && dy >= -16 && dy <= -2;
		box[2] = dx >= 8 && dx <= 10 && dy >= 2 && dy <= 16;
		box[3] = dx >= -7 && dx <= 7 && dy >= 17 && dy <= 19;
		box[4] = dx >= -10 && dx <= -8 && dy >= 2 && dy <= 16;
		box[5] = dx >= -10 && dx <= -8 && dy >= -16 && dy <= -2;
		box[6] = dx >= -7 && dx <= 7 && dy >= -1 && dy <= 1;
		hit = 1'b0;
		for (int i = 0; i < 7; i++)
			hit = hit || (box[i] && seg_on(d, i));
		return hit;
	endfunction

	function automatic logic [25:0] expected_pixel(int x, int y);
		logic [23:0] rgb;
		logic line;
		logic bp;
		logic rp;
		logic bl;
		logic blue_d;
		logic red_d;
		int bh;
		int rh;
		bh = snap[6] / 2; // scores shown halved
		rh = snap[7] / 2;
		rgb = 24'h000000;
		if (x < 144 || x > 783 || y < 35 || y > 514) begin
			rgb = 24'h000000;
		end else if (x < 660) begin
			line = x == 144 || x == 659 || y == 35 || y == 513 || y == 275;
			bp = disc(x, y, 240, snap[0], player_r) || disc(x, y, snap[1], 380, player_r);
			rp = disc(x, y, 560, snap[2], player_r) || disc(x, y, snap[3], 180, player_r);
			bl = disc(x, y, snap[4], snap[5], ball_r);
			rgb = {(rp || line || bl) ? 8'hff : 8'h00, line ? 8'hff : 8'h00,
				(bp || line || bl) ? 8'hff : 8'h00};
		end else if (x > 660) begin
			blue_d = digit_hit(x, y, bh / 10, 676, 100) || digit_hit(x, y, bh % 10, 698, 100);
			red_d = digit_hit(x, y, rh / 10, 738, 100) || digit_hit(x, y, rh % 10, 762, 100);
			if (red_d)
				rgb = 24'hff0000;
			else if (blue_d)
				rgb = 24'h0000ff;
			else
				rgb = 24'h80ffaa;
		end
		return {x >= 96, y >= 2, rgb};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %h, got %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "output mismatch on %s", name);
		end
	endtask

	task automatic take_snapshot();
		snap[0] = int'(team1_ver_pos);
		snap[1] = int'(team1_hor_pos);
		snap[2] = int'(team2_ver_pos);
		snap[3] = int'(team2_hor_pos);
		snap[4] = int'(ball_x);
		snap[5] = int'(ball_y);
		snap[6] = int'(team1_score);
		snap[7] = int'(team2_score);
	endtask

	// one pixel_en edge through the model pipeline
	task automatic model_edge();
		exp_out = exp_mid;
		exp_mid = expected_pixel(mx, my);
		edges++;
		if (mx == 799) begin
			mx = 0;
			if (my == 524) begin
				my = 0;
				take_snapshot(); // inputs seen at the wrap edge
				frames_done++;
			end else begin
				my++;
			end
		end else begin
			mx++;
		end
	endtask

	task automatic randomize_inputs();
		team1_ver_pos <= coord_t'($urandom % 800);
		team1_hor_pos <= coord_t'($urandom % 800);
		team2_ver_pos <= coord_t'($urandom % 800);
		team2_hor_pos <= coord_t'($urandom % 800);
		ball_x <= coord_t'($urandom % 800);
		ball_y <= coord_t'($urandom % 800);
		team1_score <= 7'($urandom % 128);
		team2_score <= 7'($urandom % 128);
	endtask

	task automatic run_cycle();
		@(posedge clk);
		pixel_en <= ($urandom % 10) < 6;
		if ($urandom % 4000 == 0)
			randomize_inputs(); // mid-frame change
		@(negedge clk);
		check_value("hsync", 32'(exp_out[25]), 32'(hsync));
		check_value("vsync", 32'(exp_out[24]), 32'(vsync));
		check_value("red", 32'(exp_out[23:16]), 32'(red));
		check_value("green", 32'(exp_out[15:8]), 32'(green));
		check_value("blue", 32'(exp_out[7:0]), 32'(blue));
		if (pixel_en)
			model_edge(); // edge that comes at the next posedge
	endtask

	initial begin
		int wait_cycles;
		int start_edges;
		rst = 1'b1;
		pixel_en = 1'b0;
		team1_ver_pos = coord_t'($urandom(29453) % 800); // seeds the generator
		team1_hor_pos = coord_t'($urandom % 800);
		team2_ver_pos = coord_t'($urandom % 800);
		team2_hor_pos = coord_t'($urandom % 800);
		ball_x = coord_t'($urandom % 800);
		ball_y = coord_t'($urandom % 800);
		team1_score = 7'($urandom % 128);
		team2_score = 7'($urandom % 128);
		mx = 0;
		my = 0;
		for (int i = 0; i < 8; i++)
			snap[i] = 0; // first frame sees a zero snapshot
		exp_mid = '0;
		exp_out = '0;
		frames_done = 0;
		edges = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		for (int f = 0; f < 3; f++) begin
			wait_cycles = 0;
			while (frames_done == f) begin
				run_cycle();
				wait_cycles++;
				if (wait_cycles > frame_timeout) begin
					$display("frame %0d did not complete within %0d cycles", f, frame_timeout);
					$display("TEST RESULT: FAIL");
					$fatal(1, "frame timeout");
				end
			end
		end
		// drain the last two pixels out of the pipeline
		start_edges = edges;
		wait_cycles = 0;
		while (edges < start_edges + 3) begin
			run_cycle();
			wait_cycles++;
			if (wait_cycles > 1000) begin
				$display("pipeline drain did not see enough pixel_en edges");
				$display("TEST RESULT: FAIL");
				$fatal(1, "drain timeout");
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* design/pitch_display.sv */
module pitch_display
	import pitch_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic pixel_en,

	input coord_t team1_ver_pos,
	input coord_t team1_hor_pos,
	input coord_t team2_ver_pos,
	input coord_t team2_hor_pos,
	input coord_t ball_x,
	input coord_t ball_y,
	input logic [6:0] team1_score,
	input logic [6:0] team2_score,

	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	stage_if #(.payload_t(raster_t)) s1 (); // position and frame snapshot
	stage_if #(.payload_t(layer_t)) s2 ();  // layer flags

	raster_counter raster_counter_inst (
		.clk(clk),
		.rst(rst),
		.pixel_en(pixel_en),
		.team1_ver_pos(team1_ver_pos),
		.team1_hor_pos(team1_hor_pos),
		.team2_ver_pos(team2_ver_pos),
		.team2_hor_pos(team2_hor_pos),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.team1_score(team1_score),
		.team2_score(team2_score),
		.out_s(s1.source)
	);

	scene_layers #(
		.player_radius(25),
		.ball_radius(5)
	) scene_layers_inst (
		.clk(clk),
		.rst(rst),
		.pixel_en(pixel_en),
		.in_s(s1.sink),
		.out_s(s2.source)
	);

	pixel_compositor pixel_compositor_inst (
		.clk(clk),
		.rst(rst),
		.pixel_en(pixel_en),
		.in_s(s2.sink),
		.hsync(hsync),
		.vsync(vsync),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

/* design/pitch_pkg.sv */
package pitch_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [6:0] score_t;
	typedef logic [3:0] digit_t;

	// raster timing
	localparam coord_t h_total = 10'd800;
	localparam coord_t v_total = 10'd525;
	localparam coord_t hsync_end = 10'd96; // hsync low for x below this
	localparam coord_t vsync_end = 10'd2;

	localparam coord_t act_x_min = 10'd144;
	localparam coord_t act_x_max = 10'd783;
	localparam coord_t act_y_min = 10'd35;
	localparam coord_t act_y_max = 10'd514;

	// field geometry
	localparam coord_t field_x_end = 10'd660; // separator column
	localparam coord_t border_x_l = 10'd144;
	localparam coord_t border_x_r = 10'd659;
	localparam coord_t border_y_t = 10'd35;
	localparam coord_t border_y_b = 10'd513;
	localparam coord_t half_line_y = 10'd275;

	// fixed axis of each player pair
	localparam coord_t team1_fixed_x = 10'd240;
	localparam coord_t team1_fixed_y = 10'd380;
	localparam coord_t team2_fixed_x = 10'd560;
	localparam coord_t team2_fixed_y = 10'd180;

	// score board digit origins
	localparam coord_t score_y = 10'd100;
	localparam coord_t blue_tens_x = 10'd676;
	localparam coord_t blue_ones_x = 10'd698;
	localparam coord_t red_tens_x = 10'd738;
	localparam coord_t red_ones_x = 10'd762;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t board_bg = '{red: 8'h80, green: 8'hff, blue: 8'haa};

	typedef struct packed {
		coord_t team1_ver_pos;
		coord_t team1_hor_pos;
		coord_t team2_ver_pos;
		coord_t team2_hor_pos;
		coord_t ball_x;
		coord_t ball_y;
		score_t team1_score;
		score_t team2_score;
	} game_state_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		game_state_t state;
	} raster_t;

	typedef struct packed {
		logic in_active;
		logic in_field;
		logic on_separator;
		logic on_line; // border or half line
		logic blue_player;
		logic red_player;
		logic ball;
		logic blue_digit;
		logic red_digit;
	} layer_t;

endpackage

/* design/pixel_compositor.sv */
module pixel_compositor
	import pitch_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic pixel_en,
	stage_if.sink in_s,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	layer_t l;
	rgb_t next_colour;
	rgb_t colour;
	logic hsync_q;
	logic vsync_q;

	assign l = in_s.payload;

	always_comb begin
		next_colour = '0;
		if (!l.in_active) begin
			next_colour = '0; // blanking
		end else if (l.in_field) begin
			next_colour.red = (l.red_player || l.on_line || l.ball) ? 8'hff : 8'h00;
			next_colour.green = l.on_line ? 8'hff : 8'h00;
			next_colour.blue = (l.blue_player || l.on_line || l.ball) ? 8'hff : 8'h00;
		end else if (l.on_separator) begin
			next_colour = '0;
		end else if (l.red_digit) begin
			next_colour = '{red: 8'hff, green: 8'h00, blue: 8'h00}; // red over blue
		end else if (l.blue_digit) begin
			next_colour = '{red: 8'h00, green: 8'h00, blue: 8'hff};
		end else begin
			next_colour = board_bg;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			colour <= '0;
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
		end else if (pixel_en) begin
			colour <= next_colour;
			hsync_q <= in_s.hsync;
			vsync_q <= in_s.vsync;
		end
	end

	assign hsync = hsync_q;
	assign vsync = vsync_q;
	assign red = colour.red;
	assign green = colour.green;
	assign blue = colour.blue;

endmodule

/* design/raster_counter.sv */
module raster_counter
	import pitch_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic pixel_en,

	input coord_t team1_ver_pos,
	input coord_t team1_hor_pos,
	input coord_t team2_ver_pos,
	input coord_t team2_hor_pos,
	input coord_t ball_x,
	input coord_t ball_y,
	input logic [6:0] team1_score,
	input logic [6:0] team2_score,

	stage_if.source out_s
);

	coord_t x;
	coord_t y;
	game_state_t live;
	game_state_t snap; // held for the whole frame
	logic line_end;
	logic frame_end;

	assign live = '{
		team1_ver_pos: team1_ver_pos,
		team1_hor_pos: team1_hor_pos,
		team2_ver_pos: team2_ver_pos,
		team2_hor_pos: team2_hor_pos,
		ball_x: ball_x,
		ball_y: ball_y,
		team1_score: team1_score,
		team2_score: team2_score
	};

	assign line_end = (x == h_total - 10'd1);
	assign frame_end = line_end && (y == v_total - 10'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else if (pixel_en) begin
			if (line_end) begin
				x <= '0;
				if (frame_end)
					y <= '0;
				else
					y <= y + 10'd1;
			end else begin
				x <= x + 10'd1;
			end
		end
	end

	// inputs sampled only at the frame wrap so a frame never tears
	always_ff @(posedge clk) begin
		if (rst)
			snap <= '0;
		else if (pixel_en && frame_end)
			snap <= live;
	end

	assign out_s.hsync = (x >= hsync_end); // active low
	assign out_s.vsync = (y >= vsync_end);
	assign out_s.payload = '{x: x, y: y, state: snap};

endmodule

/* design/scene_layers.sv */
module scene_layers
	import pitch_pkg::*;
#(
	parameter int player_radius = 25,
	parameter int ball_radius = 5
) (
	input logic clk,
	input logic rst,
	input logic pixel_en,
	stage_if.sink in_s,
	stage_if.source out_s
);

	localparam logic [22:0] player_r_sq = 23'(player_radius * player_radius);
	localparam logic [22:0] ball_r_sq = 23'(ball_radius * ball_radius);

	raster_t r;
	game_state_t st;
	layer_t next_layer;
	layer_t layer_q;
	logic hsync_q;
	logic vsync_q;
	logic [5:0] blue_half;
	logic [5:0] red_half;
	digit_t blue_tens;
	digit_t blue_ones;
	digit_t red_tens;
	digit_t red_ones;
	logic [3:0] glyph_hit; // blue tens, blue ones, red tens, red ones

	function automatic logic disc_hit(
		input coord_t px,
		input coord_t py,
		input coord_t cx,
		input coord_t cy,
		input logic [22:0] r_sq
	);
		logic signed [11:0] dx;
		logic signed [11:0] dy;
		logic [22:0] d_sq;
		dx = $signed({2'b00, px}) - $signed({2'b00, cx});
		dy = $signed({2'b00, py}) - $signed({2'b00, cy});
		d_sq = 23'(dx * dx) + 23'(dy * dy);
		return d_sq < r_sq;
	endfunction

	assign r = in_s.payload;
	assign st = r.state;

	// halved scores split into decimal digits
	assign blue_half = st.team1_score[6:1];
	assign red_half = st.team2_score[6:1];
	assign blue_tens = digit_t'(blue_half / 6'd10);
	assign blue_ones = digit_t'(blue_half % 6'd10);
	assign red_tens = digit_t'(red_half / 6'd10);
	assign red_ones = digit_t'(red_half % 6'd10);

	seven_seg_glyph blue_tens_glyph (.x(r.x), .y(r.y), .digit(blue_tens),
		.origin_x(blue_tens_x), .origin_y(score_y), .hit(glyph_hit[3]));
	seven_seg_glyph blue_ones_glyph (.x(r.x), .y(r.y), .digit(blue_ones),
		.origin_x(blue_ones_x), .origin_y(score_y), .hit(glyph_hit[2]));
	seven_seg_glyph red_tens_glyph (.x(r.x), .y(r.y), .digit(red_tens),
		.origin_x(red_tens_x), .origin_y(score_y), .hit(glyph_hit[1]));
	seven_seg_glyph red_ones_glyph (.x(r.x), .y(r.y), .digit(red_ones),
		.origin_x(red_ones_x), .origin_y(score_y), .hit(glyph_hit[0]));

	always_comb begin
		next_layer.in_active = (r.x >= act_x_min) && (r.x <= act_x_max)
			&& (r.y >= act_y_min) && (r.y <= act_y_max);
		next_layer.in_field = (r.x < field_x_end);
		next_layer.on_separator = (r.x == field_x_end);
		next_layer.on_line = (r.x == border_x_l) || (r.x == border_x_r)
			|| (r.y == border_y_t) || (r.y == border_y_b) || (r.y == half_line_y);
		next_layer.blue_player = disc_hit(r.x, r.y, team1_fixed_x, st.team1_ver_pos, player_r_sq)
			|| disc_hit(r.x, r.y, st.team1_hor_pos, team1_fixed_y, player_r_sq);
		next_layer.red_player = disc_hit(r.x, r.y, team2_fixed_x, st.team2_ver_pos, player_r_sq)
			|| disc_hit(r.x, r.y, st.team2_hor_pos, team2_fixed_y, player_r_sq);
		next_layer.ball = disc_hit(r.x, r.y, st.ball_x, st.ball_y, ball_r_sq);
		next_layer.blue_digit = glyph_hit[3] || glyph_hit[2];
		next_layer.red_digit = glyph_hit[1] || glyph_hit[0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			layer_q <= '0;
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
		end else if (pixel_en) begin
			layer_q <= next_layer;
			hsync_q <= in_s.hsync;
			vsync_q <= in_s.vsync;
		end
	end

	assign out_s.payload = layer_q;
	assign out_s.hsync = hsync_q;
	assign out_s.vsync = vsync_q;

endmodule

/* design/seven_seg_glyph.sv */
module seven_seg_glyph
	import pitch_pkg::*;
(
	input coord_t x,
	input coord_t y,
	input digit_t digit,
	input coord_t origin_x,
	input coord_t origin_y,
	output logic hit
);

	logic signed [11:0] dx;
	logic signed [11:0] dy;
	logic [6:0] seg_box; // top, ur, lr, bottom, ll, ul, middle
	logic [6:0] seg_lit;

	function automatic logic in_range(
		input logic signed [11:0] v,
		input int lo,
		input int hi
	);
		return (v >= lo) && (v <= hi);
	endfunction

	assign dx = $signed({2'b00, x}) - $signed({2'b00, origin_x});
	assign dy = $signed({2'b00, y}) - $signed({2'b00, origin_y});

	always_comb begin
		seg_box[0] = in_range(dx, -7, 7) && in_range(dy, -19, -17);
		seg_box[1] = in_range(dx, 8, 10) && in_range(dy, -16, -2);
		seg_box[2] = in_range(dx, 8, 10) && in_range(dy, 2, 16);
		seg_box[3] = in_range(dx, -7, 7) && in_range(dy, 17, 19);
		seg_box[4] = in_range(dx, -10, -8) && in_range(dy, 2, 16);
		seg_box[5] = in_range(dx, -10, -8) && in_range(dy, -16, -2);
		seg_box[6] = in_range(dx, -7, 7) && in_range(dy, -1, 1);
	end

	always_comb begin
		seg_lit[0] = !(digit inside {4'd1, 4'd4});
		seg_lit[1] = !(digit inside {4'd5, 4'd6});
		seg_lit[2] = (digit != 4'd2);
		seg_lit[3] = !(digit inside {4'd1, 4'd4, 4'd7});
		seg_lit[4] = (digit inside {4'd0, 4'd2, 4'd6, 4'd8}); // only a few light it
		seg_lit[5] = !(digit inside {4'd1, 4'd2, 4'd3, 4'd7});
		seg_lit[6] = !(digit inside {4'd0, 4'd1, 4'd7});
	end

	assign hit = |(seg_box & seg_lit);

endmodule

/* design/stage_if.sv */
// one pipeline stage boundary, no handshake
interface stage_if #(
	parameter type payload_t = logic
);

	logic hsync;
	logic vsync;
	payload_t payload;

	modport source (
		output hsync,
		output vsync,
		output payload
	);

	modport sink (
		input hsync,
		input vsync,
		input payload
	);

endinterface

/* files.f */
design/pitch_pkg.sv
design/stage_if.sv
design/seven_seg_glyph.sv
design/raster_counter.sv
design/scene_layers.sv
design/pixel_compositor.sv
design/pitch_display.sv
bench/tb_pitch_display.sv
